// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tb_caches
FILELIST  = src.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "STATUS: PASS" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== caches.sv ====
`timescale 1ns/100ps
`default_nettype none

module caches (
  input  wire logic                       CLK,
  input  wire logic                       nRST,
  input  wire cpu_types_pkg::icache_req_t ireq,
  output cpu_types_pkg::icache_rsp_t      irsp,
  input  wire cpu_types_pkg::dcache_req_t dreq,
  output cpu_types_pkg::dcache_rsp_t      drsp,
  output cpu_types_pkg::mem_req_t         ram_req,
  input  wire cpu_types_pkg::ram_rsp_t    ram_rsp
);

  // cache to arbiter links
  cpu_types_pkg::mem_req_t icache_mreq;
  cpu_types_pkg::mem_rsp_t icache_mrsp;
  cpu_types_pkg::mem_req_t dcache_mreq;
  cpu_types_pkg::mem_rsp_t dcache_mrsp;

  icache i_icache (
    .CLK  (CLK),
    .nRST (nRST),
    .dreq (ireq),
    .drsp (irsp),
    .mreq (icache_mreq),
    .mrsp (icache_mrsp)
  );

  dcache i_dcache (
    .CLK  (CLK),
    .nRST (nRST),
    .dreq (dreq),
    .drsp (drsp),
    .mreq (dcache_mreq),
    .mrsp (dcache_mrsp)
  );

  // single RAM port shared by both misses
  memory_arbiter i_arbiter (
    .ireq    (icache_mreq),
    .dreq    (dcache_mreq),
    .irsp    (icache_mrsp),
    .drsp    (dcache_mrsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

`default_nettype wire

// ==== caches_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module caches_checker (
  input  wire logic                       CLK,
  input  wire logic                       nRST,
  input  wire cpu_types_pkg::icache_req_t ireq,
  input  wire cpu_types_pkg::icache_rsp_t irsp,
  input  wire cpu_types_pkg::dcache_req_t dreq,
  input  wire cpu_types_pkg::dcache_rsp_t drsp,
  input  wire cpu_types_pkg::mem_req_t    ram_req,
  input  wire cpu_types_pkg::ram_rsp_t    ram_rsp,
  input  wire cpu_types_pkg::word_t       ram_init [256],
  output int                              error_count,
  output int                              check_count
);

  // shadow frames and memory
  cpu_types_pkg::cache_frame_t [cpu_types_pkg::FRAME_COUNT-1:0] i_shadow;
  cpu_types_pkg::cache_frame_t [cpu_types_pkg::FRAME_COUNT-1:0] d_shadow;
  cpu_types_pkg::word_t shadow_mem [256];

  // request still waiting for its hit
  logic i_wait;
  logic d_wait;
  // memory access raised by each controller
  logic i_refill;
  logic d_refill;
  logic d_write;

  // {hit, word} for an access against the shadows
  function automatic logic [32:0] expected_access(input logic data_side,
                                                  input cpu_types_pkg::word_t addr);
    cpu_types_pkg::cache_addr_u  a;
    cpu_types_pkg::cache_frame_t frame;
    a.raw = addr;
    frame = data_side ? d_shadow[a.f.idx] : i_shadow[a.f.idx];
    // a present frame wins, even if memory moved on
    if (frame.valid && frame.tag == a.f.tag) begin
      return {1'b1, frame.data};
    end
    return {1'b0, shadow_mem[addr[9:2]]};
  endfunction

  task automatic compare(input string name, input cpu_types_pkg::word_t expected,
                         input cpu_types_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %0s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  always @(posedge CLK) begin
    cpu_types_pkg::cache_addr_u req_addr;
    logic [32:0] exp_acc;
    logic        ram_done;
    logic        d_mem;
    ram_done = (ram_req.ren | ram_req.wen) & ~ram_rsp.busy;
    d_mem    = d_refill | d_write;
    if (!nRST) begin
      for (int k = 0; k < 256; k++) shadow_mem[k] = ram_init[k];
      i_shadow = '0;
      d_shadow = '0;
      {i_wait, d_wait, i_refill, d_refill, d_write} = '0;
      compare("ram_req.ren", 32'd0, 32'(ram_req.ren));
      compare("ram_req.wen", 32'd0, 32'(ram_req.wen));
    end else begin
      // nothing in flight, RAM port quiet
      if (!i_refill && !d_mem) begin
        compare("ram_req.ren", 32'd0, 32'(ram_req.ren));
        compare("ram_req.wen", 32'd0, 32'(ram_req.wen));
      end
      if (ireq.ren) begin
        exp_acc = expected_access(1'b0, ireq.addr);
        if (!i_wait) compare("irsp.hit", 32'(exp_acc[32]), 32'(irsp.hit));
        if (irsp.hit) compare("irsp.load", exp_acc[31:0], irsp.load);
      end
      if (dreq.ren && !dreq.wen) begin
        exp_acc = expected_access(1'b1, dreq.addr);
        if (!d_wait) compare("drsp.hit", 32'(exp_acc[32]), 32'(drsp.hit));
        if (drsp.hit) compare("drsp.load", exp_acc[31:0], drsp.load);
      end
      // write hit pulses only on completion
      if (dreq.wen) compare("drsp.hit", 32'(d_write & ram_done), 32'(drsp.hit));
      if (d_write && ram_done) begin
        compare("ram_req.addr", dreq.addr, ram_req.addr);
        compare("ram_req.store", dreq.store, ram_req.store);
        shadow_mem[dreq.addr[9:2]] = dreq.store;
        req_addr.raw = dreq.addr;
        if (d_shadow[req_addr.f.idx].valid && d_shadow[req_addr.f.idx].tag == req_addr.f.tag) begin
          d_shadow[req_addr.f.idx].data = dreq.store;
        end
      end else if (d_refill && ram_done) begin
        compare("ram_req.addr", dreq.addr, ram_req.addr);
        req_addr.raw = dreq.addr;
        d_shadow[req_addr.f.idx] = {1'b1, req_addr.f.tag, shadow_mem[dreq.addr[9:2]]};
      end else if (i_refill && ram_done) begin
        // data side has priority, so this one is the fetch
        compare("ram_req.addr", ireq.addr, ram_req.addr);
        req_addr.raw = ireq.addr;
        i_shadow[req_addr.f.idx] = {1'b1, req_addr.f.tag, shadow_mem[ireq.addr[9:2]]};
      end
      // controller phases, next edge after the request cycle
      if (d_mem) begin
        if (ram_done) {d_refill, d_write} = 2'b00;
      end else if (dreq.wen) begin
        d_write = 1'b1;
      end else if (dreq.ren && !drsp.hit) begin
        d_refill = 1'b1;
      end
      if (i_refill) begin
        if (ram_done && !d_mem) i_refill = 1'b0;
      end else if (ireq.ren && !irsp.hit) begin
        i_refill = 1'b1;
      end
      i_wait = ireq.ren & ~irsp.hit;
      d_wait = (dreq.ren | dreq.wen) & ~drsp.hit;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_types_pkg.sv ====
`default_nettype none

package cpu_types_pkg;

  // machine word, used for data and byte addresses
  typedef logic [31:0] word_t;

  // address split for a direct mapped cache of one-word frames
  localparam int TAG_W  = 26;
  localparam int IDX_W  = 4;
  localparam int BOFF_W = 2;

  // frames per cache follow from the index width
  localparam int FRAME_COUNT = 2 ** IDX_W;

  // field view of a byte address
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [BOFF_W-1:0] byte_off;
  } addr_fields_t;

  // raw word toward memory, fields inside the caches
  typedef union packed {
    word_t        raw;
    addr_fields_t f;
  } cache_addr_u;

  // one cache frame, 59 bits
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    word_t            data;
  } cache_frame_t;

  // datapath side of the instruction cache
  typedef struct packed {
    logic  ren;
    word_t addr;
  } icache_req_t;

  typedef struct packed {
    logic  hit;
    word_t load;
  } icache_rsp_t;

  // datapath side of the data cache
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dcache_req_t;

  typedef struct packed {
    logic  hit;
    word_t load;
  } dcache_rsp_t;

  // memory request, cache to arbiter and arbiter to RAM
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  // arbiter back to one cache, stall is the memory wait level
  typedef struct packed {
    logic  stall;
    word_t load;
  } mem_rsp_t;

  // RAM back to the arbiter
  typedef struct packed {
    logic  busy;
    word_t load;
  } ram_rsp_t;

endpackage

`default_nettype wire

// ==== dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache (
  input  wire logic                       CLK,
  input  wire logic                       nRST,
  input  wire cpu_types_pkg::dcache_req_t dreq,
  output cpu_types_pkg::dcache_rsp_t      drsp,
  output cpu_types_pkg::mem_req_t         mreq,
  input  wire cpu_types_pkg::mem_rsp_t    mrsp
);

  // idle, read refill, write-through
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    REFILL = 2'd1,
    WRITE  = 2'd2
  } state_t;

  cpu_types_pkg::cache_frame_t [cpu_types_pkg::FRAME_COUNT-1:0] frames, frames_nxt;
  cpu_types_pkg::cache_addr_u addr;
  cpu_types_pkg::cache_addr_u addr_reg;
  state_t state, state_nxt;
  logic   match;
  logic   fill;
  logic   wr_done;
  logic   rd_hit;

  assign addr.raw = dreq.addr;

  // frame holds the requested address
  assign match = frames[addr.f.idx].valid
                 & (frames[addr.f.idx].tag == addr.f.tag);

  // completion of either memory access
  assign fill    = (state == REFILL) & ~mrsp.stall;
  assign wr_done = (state == WRITE) & ~mrsp.stall;

  // read hit only, a pending write must not see it
  assign rd_hit = ~fill & ~dreq.wen & match;

  always_comb begin
    // write completion pulses hit for one cycle
    drsp.hit  = rd_hit | wr_done;
    drsp.load = frames[addr.f.idx].data;
  end

  always_comb begin
    mreq       = '0;
    mreq.ren   = (state == REFILL);
    mreq.wen   = (state == WRITE);
    mreq.addr  = addr_reg.raw;
    // store word is held by the datapath until hit
    mreq.store = dreq.store;
  end

  always_comb begin
    frames_nxt = frames;
    if (fill) begin
      frames_nxt[addr.f.idx].valid = 1'b1;
      frames_nxt[addr.f.idx].tag   = addr.f.tag;
      frames_nxt[addr.f.idx].data  = mrsp.load;
    end else if (wr_done && match) begin
      // write-through also updates a present frame
      // a write miss leaves the array alone
      frames_nxt[addr.f.idx].data = dreq.store;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // writes always go to memory
        if (dreq.wen) begin
          state_nxt = WRITE;
        end else if (dreq.ren && !rd_hit) begin
          state_nxt = REFILL;
        end
      end
      REFILL: begin
        if (!mrsp.stall) begin
          state_nxt = IDLE;
        end
      end
      WRITE: begin
        if (!mrsp.stall) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      addr_reg <= '0;
      frames   <= '0;
    end else begin
      state    <= state_nxt;
      addr_reg <= addr;
      frames   <= frames_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache (
  input  wire logic                       CLK,
  input  wire logic                       nRST,
  input  wire cpu_types_pkg::icache_req_t dreq,
  output cpu_types_pkg::icache_rsp_t      drsp,
  output cpu_types_pkg::mem_req_t         mreq,
  input  wire cpu_types_pkg::mem_rsp_t    mrsp
);

  // two-state refill controller
  typedef enum logic {
    IDLE   = 1'b0,
    REFILL = 1'b1
  } state_t;

  cpu_types_pkg::cache_frame_t [cpu_types_pkg::FRAME_COUNT-1:0] frames, frames_nxt;
  cpu_types_pkg::cache_addr_u addr;
  cpu_types_pkg::cache_addr_u addr_reg;
  state_t state, state_nxt;
  logic   fill;
  logic   hit;

  // fetch address seen through its fields
  assign addr.raw = dreq.addr;

  // refill completes when memory drops stall
  assign fill = (state == REFILL) & ~mrsp.stall;

  // hit needs a valid frame with matching tag
  // held low while the frame is being written
  assign hit = ~fill & frames[addr.f.idx].valid
               & (frames[addr.f.idx].tag == addr.f.tag);

  always_comb begin
    drsp.hit  = hit;
    drsp.load = frames[addr.f.idx].data;
  end

  // read only toward memory
  always_comb begin
    mreq       = '0;
    mreq.ren   = (state == REFILL);
    mreq.addr  = addr_reg.raw;
  end

  always_comb begin
    frames_nxt = frames;
    // write tag, data and valid on the completion edge
    if (fill) begin
      frames_nxt[addr.f.idx].valid = 1'b1;
      frames_nxt[addr.f.idx].tag   = addr.f.tag;
      frames_nxt[addr.f.idx].data  = mrsp.load;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // miss starts a refill
        if (dreq.ren && !hit) begin
          state_nxt = REFILL;
        end
      end
      REFILL: begin
        if (!mrsp.stall) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      addr_reg <= '0;
      frames   <= '0;
    end else begin
      state    <= state_nxt;
      // address follows the datapath every cycle
      addr_reg <= addr;
      frames   <= frames_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== memory_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_arbiter (
  input  wire cpu_types_pkg::mem_req_t ireq,
  input  wire cpu_types_pkg::mem_req_t dreq,
  output cpu_types_pkg::mem_rsp_t      irsp,
  output cpu_types_pkg::mem_rsp_t      drsp,
  output cpu_types_pkg::mem_req_t      ram_req,
  input  wire cpu_types_pkg::ram_rsp_t ram_rsp
);

  logic d_active;
  logic i_active;
  logic d_grant;
  logic i_grant;

  // a cache is requesting when either enable is up
  assign d_active = dreq.ren | dreq.wen;
  assign i_active = ireq.ren | ireq.wen;

  // data cache first, instruction cache only when data is quiet
  assign d_grant = d_active;
  assign i_grant = i_active & ~d_active;

  // forward the winner to the RAM port
  always_comb begin
    if (d_grant) begin
      ram_req = dreq;
    end else if (i_grant) begin
      ram_req = ireq;
    end else begin
      // idle port, both enables low
      ram_req = '0;
    end
  end

  // stall drops only for the granted cache once RAM is free
  // losing or idle cache sees stall high
  always_comb begin
    drsp.stall = ~(d_grant & ~ram_rsp.busy);
    drsp.load  = ram_rsp.load;
  end

  always_comb begin
    irsp.stall = ~(i_grant & ~ram_rsp.busy);
    irsp.load  = ram_rsp.load;
  end

endmodule

`default_nettype wire

// ==== src.f ====
cpu_types_pkg.sv
icache.sv
dcache.sv
memory_arbiter.sv
caches.sv
caches_checker.sv
tb_caches.sv

// ==== tb_caches.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_caches;

  localparam int TIMEOUT = 200;

  logic CLK = 1'b0;
  logic nRST = 1'b0;
  cpu_types_pkg::icache_req_t ireq = '0;
  cpu_types_pkg::icache_rsp_t irsp;
  cpu_types_pkg::dcache_req_t dreq = '0;
  cpu_types_pkg::dcache_rsp_t drsp;
  cpu_types_pkg::mem_req_t    ram_req;
  cpu_types_pkg::ram_rsp_t    ram_rsp = '0;

  // RAM model, word index from address bits 9 to 2
  cpu_types_pkg::word_t ram [256];
  int   busy_left = 0;
  logic done_q = 1'b0;
  logic held_q = 1'b0;

  int error_count;
  int check_count;
  int timeouts = 0;
  int test_base = 0;

  always #10 CLK = ~CLK;

  caches i_caches (
    .CLK     (CLK),
    .nRST    (nRST),
    .ireq    (ireq),
    .irsp    (irsp),
    .dreq    (dreq),
    .drsp    (drsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

  caches_checker i_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .ireq        (ireq),
    .irsp        (irsp),
    .dreq        (dreq),
    .drsp        (drsp),
    .ram_req     (ram_req),
    .ram_rsp     (ram_rsp),
    .ram_init    (ram),
    .error_count (error_count),
    .check_count (check_count)
  );

  // random contents, then completion and writes on each rising edge
  initial begin
    void'($urandom(32'h1cedbe5c));
    foreach (ram[k]) ram[k] = $urandom();
    forever begin
      @(posedge CLK);
      done_q <= 1'b0;
      held_q <= 1'b0;
      if (ram_req.ren || ram_req.wen) begin
        if (ram_rsp.busy) begin
          held_q <= 1'b1;
        end else begin
          done_q <= 1'b1;
          if (ram_req.wen) ram[ram_req.addr[9:2]] <= ram_req.store;
        end
      end
    end
  end

  // busy and read data change on the falling edge
  // each access gets a fresh 0 to 3 busy cycles
  always @(negedge CLK) begin
    if (done_q) begin
      busy_left = $urandom_range(3, 0);
    end else if (held_q && busy_left > 0) begin
      busy_left = busy_left - 1;
    end
    ram_rsp.busy <= (busy_left != 0);
    ram_rsp.load <= ram[ram_req.addr[9:2]];
  end

  // sampled at rising edges, bounded by TIMEOUT
  task automatic await_hit(input logic data_side, input string what);
    int n;
    n = 0;
    @(posedge CLK);
    while (!(data_side ? drsp.hit : irsp.hit) && n < TIMEOUT) begin
      n++;
      @(posedge CLK);
    end
    if (!(data_side ? drsp.hit : irsp.hit)) begin
      timeouts++;
      $display("Timeout at %0t: the %0s got no hit within %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic fetch(input cpu_types_pkg::word_t addr);
    ireq.ren  = 1'b1;
    ireq.addr = addr;
    await_hit(1'b0, "instruction fetch");
    @(negedge CLK);
    ireq.ren = 1'b0;
  endtask

  task automatic load_word(input cpu_types_pkg::word_t addr);
    dreq.ren  = 1'b1;
    dreq.wen  = 1'b0;
    dreq.addr = addr;
    await_hit(1'b1, "data read");
    @(negedge CLK);
    dreq.ren = 1'b0;
  endtask

  task automatic store_word(input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t data);
    dreq.ren   = 1'b0;
    dreq.wen   = 1'b1;
    dreq.addr  = addr;
    dreq.store = data;
    await_hit(1'b1, "data write");
    @(negedge CLK);
    dreq.wen = 1'b0;
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = error_count + timeouts;
    $display("test %0s done, %0d errors", name, errs - test_base);
    test_base = errs;
  endtask

  initial begin
    cpu_types_pkg::word_t x;
    cpu_types_pkg::word_t y;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    // quiet port after reset, then first touches miss
    repeat (3) @(negedge CLK);
    fetch(32'h0000_0010);
    load_word(32'h0000_0024);
    report_test("reset");

    // miss then a hit in the request cycle
    for (int k = 0; k < 6; k++) begin
      x = 256 + k * 20;
      fetch(x);
      fetch(x);
    end
    report_test("instruction fetch");

    for (int k = 0; k < 6; k++) begin
      x = 512 + k * 20;
      load_word(x);
      load_word(x);
    end
    report_test("data read");

    x = 32'h0000_0300;
    fetch(x);
    load_word(x);
    store_word(x, 32'h5a5a_0001);
    load_word(x);
    // instruction frame keeps the old word
    fetch(x);
    // write miss, no allocate
    store_word(x + 4, 32'h5a5a_0002);
    load_word(x + 4);
    report_test("write-through");

    // index 0, tags 1 and 2
    x = 32'h0000_0040;
    y = 32'h0000_0080;
    fetch(x);
    load_word(x);
    load_word(y);
    load_word(x);
    fetch(x);
    fetch(y);
    fetch(x);
    load_word(x);
    report_test("conflict");

    for (int k = 0; k < 16; k++) begin
      x = $urandom_range(255, 0) << 2;
      y = $urandom_range(255, 0) << 2;
      fork
        fetch(x);
        load_word(y);
      join
    end
    report_test("concurrent misses");

    repeat (2) @(negedge CLK);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
